/* verilog/rop_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP agent configuration
// lane count, field widths and the payload types
// carried on the ROP bus and the commit path
// ~~~~~~~~~~~~~~~~~~~~

package rop_cfg_pkg;

    // SIMD lanes per execute request
    localparam int num_lanes  = 4;

    // fragment field widths
    localparam int dim_bits   = 15;
    localparam int depth_bits = 24;
    localparam int color_bits = 32;

    // core-side identifiers
    localparam int uuid_bits  = 16;
    localparam int nw_bits    = 2;
    localparam int xlen       = 32;

    // fragment request sent to the ROP pipeline
    typedef struct packed {
        logic [uuid_bits-1:0]                       uuid;
        logic [num_lanes-1:0]                       mask;
        logic [num_lanes-1:0][dim_bits-1:0]         pos_x;
        logic [num_lanes-1:0][dim_bits-1:0]         pos_y;
        logic [num_lanes-1:0][color_bits-1:0]       color;
        logic [num_lanes-1:0][depth_bits-1:0]       depth;
        logic [num_lanes-1:0]                       face;
    } frag_req_t;

    // commit record returned to the core
    // no write-back, so no data or rd fields
    typedef struct packed {
        logic [uuid_bits-1:0] uuid;
        logic [nw_bits-1:0]   wid;
        logic [num_lanes-1:0] tmask;
        logic [xlen-1:0]      pc;
        logic                 sop;
        logic                 eop;
    } commit_t;

endpackage

/* verilog/rop_csr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP register map
// APB addresses and reset values of the ROP registers
// ~~~~~~~~~~~~~~~~~~~~

package rop_csr_pkg;

    // APB address and data widths
    localparam int csr_addr_bits = 4;
    localparam int csr_data_bits = 32;

    // color write mask, read/write
    localparam logic [csr_addr_bits-1:0] csr_color_mask_addr = 4'h0;

    // accepted request count, read only
    localparam logic [csr_addr_bits-1:0] csr_req_count_addr  = 4'h4;

    // all color channels enabled out of reset
    localparam logic [csr_data_bits-1:0] csr_color_mask_reset = 32'hFFFF_FFFF;

    // counter saturates here instead of wrapping
    localparam logic [csr_data_bits-1:0] csr_count_max = 32'hFFFF_FFFF;

    // value returned on a read of an unmapped address
    localparam logic [csr_data_bits-1:0] csr_read_default = '0;

endpackage

/* verilog/rop_elastic_buf.sv */
// ~~~~~~~~~~~~~~~~~~~~
// two-entry elastic buffer
// registered output plus skid entry, ready_in from a flop
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rop_elastic_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid_in,
    output logic     ready_in,
    input  payload_t data_in,
    output logic     valid_out,
    input  logic     ready_out,
    output payload_t data_out
);

    logic     out_valid_q;
    logic     skid_valid_q;
    logic     ready_q;
    payload_t out_data_q;
    payload_t skid_data_q;

    logic     out_valid_d;
    logic     skid_valid_d;
    logic     push;
    logic     load_out;
    logic     load_skid;
    logic     take_skid;

    assign ready_in  = ready_q;
    assign push      = valid_in & ready_q;
    assign valid_out = out_valid_q;
    assign data_out  = out_data_q;

    always_comb begin
        out_valid_d  = out_valid_q;
        skid_valid_d = skid_valid_q;
        load_out     = 1'b0;
        load_skid    = 1'b0;
        take_skid    = 1'b0;
        if (skid_valid_q) begin
            // both full, drain the skid entry forward on a pop
            if (ready_out) begin
                skid_valid_d = 1'b0;
                take_skid    = 1'b1;
            end
        end else if (push) begin
            if (!out_valid_q || ready_out) begin
                out_valid_d = 1'b1;
                load_out    = 1'b1;
            end else begin
                skid_valid_d = 1'b1;
                load_skid    = 1'b1;
            end
        end else if (ready_out) begin
            out_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_d;
            skid_valid_q <= skid_valid_d;
            ready_q      <= ~skid_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data_q <= data_in;
        end else if (take_skid) begin
            out_data_q <= skid_data_q;
        end
        if (load_skid) begin
            skid_data_q <= data_in;
        end
    end

    // stalled output must hold its value
    assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

    // with both entries occupied the input side must be closed
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid_q && skid_valid_q |-> !push);

endmodule

/* verilog/rop_csr_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP register file on APB
// color write mask and saturating accepted-request counter
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rop_csr_regs import rop_csr_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [csr_addr_bits-1:0] paddr,
    input  logic [csr_data_bits-1:0] pwdata,
    output logic [csr_data_bits-1:0] prdata,
    output logic                     pslverr,
    input  logic                     exe_fire,
    output logic [csr_data_bits-1:0] color_mask
);

    logic [csr_data_bits-1:0] color_mask_q;
    logic [csr_data_bits-1:0] count_q;

    logic access;
    logic hit_mask;
    logic hit_count;
    logic mask_wr;
    logic bad_access;

    // zero wait states, so every access phase completes
    assign access    = psel & penable;
    assign hit_mask  = (paddr == csr_color_mask_addr);
    assign hit_count = (paddr == csr_req_count_addr);
    assign mask_wr   = access & pwrite & hit_mask;

    // count is read only and anything else is unmapped
    assign bad_access = access & ((pwrite & !hit_mask) | (!pwrite & !hit_mask & !hit_count));

    assign pslverr    = bad_access;
    assign color_mask = color_mask_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color_mask_q <= csr_color_mask_reset;
        end else if (mask_wr) begin
            color_mask_q <= pwdata;
        end
    end

    // one count per accepted execute request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (exe_fire && count_q != csr_count_max) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_comb begin
        prdata = csr_read_default;
        if (access && !pwrite) begin
            if (hit_mask) begin
                prdata = color_mask_q;
            end else if (hit_count) begin
                prdata = count_q;
            end
        end
    end

    // an access phase is always entered from a setup phase of the same transfer
    assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel && $past(psel && !penable));

endmodule

/* verilog/rop_agent.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP agent
// unpacks lane operands into fragments and forks each
// request into the ROP bus and the commit path
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rop_agent import rop_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           arst_n,

    // execute request from the special-function pipe
    input  logic                           exe_valid,
    output logic                           exe_ready,
    input  logic [uuid_bits-1:0]           exe_uuid,
    input  logic [nw_bits-1:0]             exe_wid,
    input  logic [num_lanes-1:0]           exe_tmask,
    input  logic [xlen-1:0]                exe_pc,
    input  logic                           exe_sop,
    input  logic                           exe_eop,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs1,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs2,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs3,

    // register file side
    input  logic [xlen-1:0]                color_mask,
    output logic                           exe_fire,

    // ROP bus
    output logic                           rop_req_valid,
    input  logic                           rop_req_ready,
    output frag_req_t                      rop_req_data,

    // commit to the core
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output commit_t                        commit_data
);

    frag_req_t req_in;
    commit_t   rsp_in;

    logic req_valid_in;
    logic req_ready_in;
    logic rsp_valid_in;
    logic rsp_ready_in;

    // per-lane operand layout
    // rs1 = {.., y[30:16], x[15:1], face[0]}, rs2 = color, rs3 = depth
    always_comb begin
        req_in.uuid = exe_uuid;
        req_in.mask = exe_tmask;
        for (int i = 0; i < num_lanes; i++) begin
            req_in.face[i]  = exe_rs1[i][0];
            req_in.pos_x[i] = exe_rs1[i][1 +: dim_bits];
            req_in.pos_y[i] = exe_rs1[i][16 +: dim_bits];
            req_in.color[i] = exe_rs2[i][color_bits-1:0] & color_mask[color_bits-1:0];
            req_in.depth[i] = exe_rs3[i][depth_bits-1:0];
        end
    end

    always_comb begin
        rsp_in.uuid  = exe_uuid;
        rsp_in.wid   = exe_wid;
        rsp_in.tmask = exe_tmask;
        rsp_in.pc    = exe_pc;
        rsp_in.sop   = exe_sop;
        rsp_in.eop   = exe_eop;
    end

    // joint-ready fork where each half enqueues only when the other one can too
    assign req_valid_in = exe_valid & rsp_ready_in;
    assign rsp_valid_in = exe_valid & req_ready_in;
    assign exe_ready    = req_ready_in & rsp_ready_in;
    assign exe_fire     = exe_valid & exe_ready;

    rop_elastic_buf #(
        .payload_t (frag_req_t)
    ) req_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (req_valid_in),
        .ready_in  (req_ready_in),
        .data_in   (req_in),
        .valid_out (rop_req_valid),
        .ready_out (rop_req_ready),
        .data_out  (rop_req_data)
    );

    rop_elastic_buf #(
        .payload_t (commit_t)
    ) rsp_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (rsp_valid_in),
        .ready_in  (rsp_ready_in),
        .data_in   (rsp_in),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (commit_data)
    );

    // both halves of an accepted request are held by the buffers one cycle later
    assert property (@(posedge clk) disable iff (!arst_n)
        exe_fire |=> rop_req_valid && commit_valid);

endmodule

/* verilog/rop_unit_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP unit top level
// agent plus APB register file
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rop_unit_top import rop_cfg_pkg::*, rop_csr_pkg::*; (
    input  logic                           clk,
    input  logic                           arst_n,

    // execute request
    input  logic                           exe_valid,
    output logic                           exe_ready,
    input  logic [uuid_bits-1:0]           exe_uuid,
    input  logic [nw_bits-1:0]             exe_wid,
    input  logic [num_lanes-1:0]           exe_tmask,
    input  logic [xlen-1:0]                exe_pc,
    input  logic                           exe_sop,
    input  logic                           exe_eop,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs1,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs2,
    input  logic [num_lanes-1:0][xlen-1:0] exe_rs3,

    // ROP bus
    output logic                           rop_req_valid,
    input  logic                           rop_req_ready,
    output frag_req_t                      rop_req_data,

    // commit
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output commit_t                        commit_data,

    // APB register port
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [csr_addr_bits-1:0]       paddr,
    input  logic [csr_data_bits-1:0]       pwdata,
    output logic [csr_data_bits-1:0]       prdata,
    output logic                           pslverr
);

    logic [csr_data_bits-1:0] color_mask;
    logic                     exe_fire;

    rop_agent i_agent (
        .clk           (clk),
        .arst_n        (arst_n),
        .exe_valid     (exe_valid),
        .exe_ready     (exe_ready),
        .exe_uuid      (exe_uuid),
        .exe_wid       (exe_wid),
        .exe_tmask     (exe_tmask),
        .exe_pc        (exe_pc),
        .exe_sop       (exe_sop),
        .exe_eop       (exe_eop),
        .exe_rs1       (exe_rs1),
        .exe_rs2       (exe_rs2),
        .exe_rs3       (exe_rs3),
        .color_mask    (color_mask),
        .exe_fire      (exe_fire),
        .rop_req_valid (rop_req_valid),
        .rop_req_ready (rop_req_ready),
        .rop_req_data  (rop_req_data),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit_data   (commit_data)
    );

    rop_csr_regs i_csr (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .exe_fire   (exe_fire),
        .color_mask (color_mask)
    );

endmodule

/* bench/rop_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// ROP unit testbench
// execute stream with back-pressure, model compare
// and APB register checks
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rop_tb import rop_cfg_pkg::*, rop_csr_pkg::*; ();

    localparam int stream_reqs = 200;
    localparam int mask_reqs   = 20;
    // one directed request plus the two random streams, 4 cycles each at worst
    localparam int cycle_limit = (1 + stream_reqs + mask_reqs) * 4 + 500;

    logic                           clk           = 1'b0;
    logic                           arst_n        = 1'b0;
    logic                           exe_valid     = 1'b0;
    logic                           exe_ready;
    logic [uuid_bits-1:0]           exe_uuid      = '0;
    logic [nw_bits-1:0]             exe_wid       = '0;
    logic [num_lanes-1:0]           exe_tmask     = '0;
    logic [xlen-1:0]                exe_pc        = '0;
    logic                           exe_sop       = 1'b0;
    logic                           exe_eop       = 1'b0;
    logic [num_lanes-1:0][xlen-1:0] exe_rs1       = '0;
    logic [num_lanes-1:0][xlen-1:0] exe_rs2       = '0;
    logic [num_lanes-1:0][xlen-1:0] exe_rs3       = '0;
    logic                           rop_req_valid;
    logic                           rop_req_ready = 1'b1;
    frag_req_t                      rop_req_data;
    logic                           commit_valid;
    logic                           commit_ready  = 1'b1;
    commit_t                        commit_data;
    logic                           psel          = 1'b0;
    logic                           penable       = 1'b0;
    logic                           pwrite        = 1'b0;
    logic [csr_addr_bits-1:0]       paddr         = '0;
    logic [csr_data_bits-1:0]       pwdata        = '0;
    logic [csr_data_bits-1:0]       prdata;
    logic                           pslverr;

    // expected traffic, filled at each execute handshake
    frag_req_t   exp_frag[$];
    commit_t     exp_commit[$];
    frag_req_t   last_frag;
    logic [31:0] cur_mask     = 32'hFFFF_FFFF;
    logic        rand_ready   = 1'b0;
    string       test_name    = "reset";
    int          cmp_errors   = 0;
    int          chk_errors   = 0;
    int          test_start   = 0;
    int          accept_count = 0;
    int          cycles       = 0;
    int          pass_count   = 0;
    int          fail_count   = 0;

    rop_unit_top i_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, test %s never completed", cycles, test_name);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // output back-pressure, random only during the stream test
    always @(negedge clk) begin
        if (rand_ready) begin
            rop_req_ready = ($urandom % 4) != 0;
            commit_ready  = ($urandom % 4) != 0;
        end else begin
            rop_req_ready = 1'b1;
            commit_ready  = 1'b1;
        end
    end

    // rs1 holds y in bits 30:16, x in 15:1 and face in bit 0
    function automatic frag_req_t model_frag(
        input logic [num_lanes-1:0][xlen-1:0] rs1,
        input logic [num_lanes-1:0][xlen-1:0] rs2,
        input logic [num_lanes-1:0][xlen-1:0] rs3,
        input logic [num_lanes-1:0]           tmask,
        input logic [uuid_bits-1:0]           uuid,
        input logic [31:0]                    mask
    );
        frag_req_t f;
        f.uuid = uuid;
        f.mask = tmask;
        for (int i = 0; i < num_lanes; i++) begin
            f.face[i]  = rs1[i][0];
            f.pos_x[i] = rs1[i][15:1];
            f.pos_y[i] = rs1[i][30:16];
            f.color[i] = rs2[i] & mask;
            f.depth[i] = rs3[i][23:0];
        end
        return f;
    endfunction

    // pops on output handshakes, pushes on execute handshakes
    always @(posedge clk) begin
        frag_req_t ef;
        commit_t   ec;
        if (rop_req_valid && rop_req_ready) begin
            if (exp_frag.size() == 0) begin
                $display("unexpected fragment on the ROP bus in test %s", test_name);
                cmp_errors++;
            end else begin
                ef = exp_frag.pop_front();
                last_frag = rop_req_data;
                if (rop_req_data !== ef) begin
                    $display("** Error %s: fragment expected %h, actual %h",
                             test_name, ef, rop_req_data);
                    cmp_errors++;
                end
            end
        end
        if (commit_valid && commit_ready) begin
            if (exp_commit.size() == 0) begin
                $display("unexpected commit record in test %s", test_name);
                cmp_errors++;
            end else begin
                ec = exp_commit.pop_front();
                if (commit_data !== ec) begin
                    $display("** Error %s: commit expected %h, actual %h",
                             test_name, ec, commit_data);
                    cmp_errors++;
                end
            end
        end
        if (arst_n && exe_valid && exe_ready) begin
            exp_frag.push_back(model_frag(exe_rs1, exe_rs2, exe_rs3, exe_tmask,
                                          exe_uuid, cur_mask));
            ec.uuid  = exe_uuid;
            ec.wid   = exe_wid;
            ec.tmask = exe_tmask;
            ec.pc    = exe_pc;
            ec.sop   = exe_sop;
            ec.eop   = exe_eop;
            exp_commit.push_back(ec);
            accept_count++;
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
            chk_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = cmp_errors + chk_errors;
    endtask

    task automatic finish_test();
        if (cmp_errors + chk_errors == test_start) begin
            $display("test %-12s ok", test_name);
            pass_count++;
        end else begin
            $display("test %-12s failed with %0d errors", test_name,
                     cmp_errors + chk_errors - test_start);
            fail_count++;
        end
    endtask

    // setup phase, then a zero-wait access phase
    task automatic apb_write(input logic [csr_addr_bits-1:0] addr, input logic [31:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [csr_addr_bits-1:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_random(input logic [uuid_bits-1:0] uuid);
        logic [31:0] r;
        r = $urandom;
        exe_uuid  = uuid;
        exe_wid   = r[nw_bits-1:0];
        exe_tmask = r[8 +: num_lanes];
        exe_sop   = r[16];
        exe_eop   = r[17];
        exe_pc    = $urandom;
        for (int i = 0; i < num_lanes; i++) begin
            exe_rs1[i] = $urandom;
            exe_rs2[i] = $urandom;
            exe_rs3[i] = $urandom;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic push_req();
        exe_valid = 1'b1;
        while (!exe_ready) @(negedge clk);
        @(negedge clk);
        exe_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_frag.size() != 0 || exp_commit.size() != 0) @(negedge clk);
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] seed;
        seed = $urandom(19041);
        repeat (2) @(negedge clk);

        start_test("reset");
        check_val("exe_ready in reset", 0, 32'(exe_ready));
        arst_n = 1'b1;
        @(negedge clk);
        check_val("rop_req_valid", 0, 32'(rop_req_valid));
        check_val("commit_valid", 0, 32'(commit_valid));
        apb_read(csr_color_mask_addr, rd, err);
        check_val("color mask", 32'hFFFF_FFFF, rd);
        apb_read(csr_req_count_addr, rd, err);
        check_val("request count", 0, rd);
        finish_test();

        start_test("single");
        exe_uuid  = 16'hBEEF;
        exe_wid   = 2'd2;
        exe_tmask = 4'b1011;
        exe_pc    = 32'h8000_1234;
        exe_sop   = 1'b1;
        exe_eop   = 1'b1;
        for (int i = 0; i < num_lanes; i++) begin
            exe_rs1[i] = 32'h7FFE_8003 - 32'(i) * 32'h0002_0002;
            exe_rs2[i] = 32'hC0FF_EE00 + 32'(i);
            exe_rs3[i] = 32'hAB12_3456 + 32'(i);
        end
        push_req();
        wait_drain();
        // lane 0 worked out by hand from the operand layout
        check_val("lane 0 face", 1, 32'(last_frag.face[0]));
        check_val("lane 0 x", 32'h4001, 32'(last_frag.pos_x[0]));
        check_val("lane 0 y", 32'h7FFE, 32'(last_frag.pos_y[0]));
        check_val("lane 0 color", 32'hC0FF_EE00, last_frag.color[0]);
        check_val("lane 0 depth", 32'h0012_3456, 32'(last_frag.depth[0]));
        check_val("mask", 32'hB, 32'(last_frag.mask));
        finish_test();

        start_test("stream");
        rand_ready = 1'b1;
        for (int n = 0; n < stream_reqs; n++) begin
            load_random(16'(n + 256));
            push_req();
            if ($urandom % 4 == 0) begin
                @(negedge clk);
            end
        end
        wait_drain();
        rand_ready = 1'b0;
        finish_test();

        start_test("color mask");
        apb_write(csr_color_mask_addr, 32'h00FF_F0F0, err);
        check_val("mask write pslverr", 0, 32'(err));
        cur_mask = 32'h00FF_F0F0;
        apb_read(csr_color_mask_addr, rd, err);
        check_val("mask readback", 32'h00FF_F0F0, rd);
        for (int n = 0; n < mask_reqs; n++) begin
            load_random(16'(n + 1024));
            push_req();
        end
        wait_drain();
        finish_test();

        start_test("count");
        apb_read(csr_req_count_addr, rd, err);
        check_val("count read pslverr", 0, 32'(err));
        check_val("request count", 32'(accept_count), rd);
        finish_test();

        start_test("bad write");
        apb_write(4'h8, 32'h1234_5678, err);
        check_val("unmapped write pslverr", 1, 32'(err));
        apb_write(csr_req_count_addr, 32'h0000_0055, err);
        check_val("count write pslverr", 1, 32'(err));
        apb_read(csr_color_mask_addr, rd, err);
        check_val("color mask", cur_mask, rd);
        apb_read(csr_req_count_addr, rd, err);
        check_val("request count", 32'(accept_count), rd);
        finish_test();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/rop_cfg_pkg.sv
verilog/rop_csr_pkg.sv
verilog/rop_elastic_buf.sv
verilog/rop_csr_regs.sv
verilog/rop_agent.sv
verilog/rop_unit_top.sv
bench/rop_tb.sv

/* Makefile */
SIM := obj_dir/Vrop_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f verilog/*.sv bench/*.sv
	verilator --binary --timing --assert -j 0 --top-module rop_tb -f project.f

# the run passes only if the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir
